//--- cdb_arbiter.sv
// fixed priority, lowest index wins, up to CDB_NUM grants per cycle
// purely combinational, the requester must hold req/addr/data until granted
// unused cdb ports are invalid with zero payload
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module cdb_arbiter (
  // completion requests
  input  wire logic [`FU_NUM-1:0]                     fu_req_i,
  input  wire regread_pkg::preg_t [`FU_NUM-1:0]       fu_addr_i,
  input  wire regread_pkg::data_t [`FU_NUM-1:0]       fu_data_i,
  output logic [`FU_NUM-1:0]                          fu_gnt_o,   // same cycle
  // cdb broadcast
  output logic [`CDB_NUM-1:0]                         cdb_valid_o,
  output regread_pkg::preg_t [`CDB_NUM-1:0]           cdb_addr_o,
  output regread_pkg::data_t [`CDB_NUM-1:0]           cdb_data_o
);

  // requests not yet claimed by a lower port
  logic [`FU_NUM-1:0] avail;

  // ------------------------------------------------------------------------
  // port assignment
  // ------------------------------------------------------------------------
  // port 0 takes the lowest requester, port 1 the next one up, and so on
  // each port looks at what the ports before it left over

  always_comb begin
    avail       = fu_req_i;    // everything pending is a candidate
    fu_gnt_o    = '0;
    cdb_valid_o = '0;
    cdb_addr_o  = '0;          // idle port carries zeros
    cdb_data_o  = '0;

    for (int p = 0; p < `CDB_NUM; p++) begin
      for (int i = 0; i < `FU_NUM; i++) begin
        // first free requester only, port already filled otherwise
        if (avail[i] && !cdb_valid_o[p]) begin
          cdb_valid_o[p] = 1'b1;
          cdb_addr_o[p]  = fu_addr_i[i];   // steer payload
          cdb_data_o[p]  = fu_data_i[i];
          fu_gnt_o[i]    = 1'b1;
          avail[i]       = 1'b0;           // claimed, skip on later ports
        end
      end
    end
    // whatever is left in avail stays pending, fu holds it
  end

endmodule

`default_nettype wire

//--- operand_read.sv
// operand-read pipeline register, one stage between prf read and execute
// tag and operands only load for a valid slot and hold otherwise
// consumers must look at op_valid_o before using the payload
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module operand_read (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_i,
  // issue slots, values already read from the prf
  input  wire logic [`IS_NUM-1:0]                     is_valid_i,
  input  wire regread_pkg::tag_t [`IS_NUM-1:0]        is_tag_i,
  input  wire regread_pkg::data_t [`IS_NUM-1:0]       src1_data_i,
  input  wire regread_pkg::data_t [`IS_NUM-1:0]       src2_data_i,
  // to execute
  output logic [`IS_NUM-1:0]                          op_valid_o,
  output regread_pkg::tag_t [`IS_NUM-1:0]             op_tag_o,
  output regread_pkg::data_t [`IS_NUM-1:0]            op_data1_o,
  output regread_pkg::data_t [`IS_NUM-1:0]            op_data2_o
);

  // ------------------------------------------------------------------------
  // valid, the only control state here
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_valid_o <= '0;
    end else begin
      op_valid_o <= is_valid_i;   // invalid slot drops to 0 next cycle
    end
  end

  // ------------------------------------------------------------------------
  // payload, per slot load enable
  // ------------------------------------------------------------------------
  // idle slots keep their old contents, saves toggling into execute

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < `IS_NUM; s++) begin
      if (is_valid_i[s]) begin
        op_tag_o[s]   <= is_tag_i[s];
        op_data1_o[s] <= src1_data_i[s];
        op_data2_o[s] <= src2_data_i[s];
      end
    end
  end

endmodule

`default_nettype wire

//--- phys_regfile.sv
// physical register file, CDB_NUM write ports, IS_NUM slots x 2 read ports
// reads are combinational with forwarding from same-cycle writes
// two writes to one address are not expected, port 1 wins if they happen
// reg 0 may be written but always reads as zero
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module phys_regfile (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_i,
  // write side, from the cdb
  input  wire logic [`CDB_NUM-1:0]                    wr_en_i,
  input  wire regread_pkg::preg_t [`CDB_NUM-1:0]      wr_addr_i,
  input  wire regread_pkg::data_t [`CDB_NUM-1:0]      wr_data_i,
  // read side, one pair per issue slot
  input  wire regread_pkg::preg_t [`IS_NUM-1:0]       rd_addr1_i,
  input  wire regread_pkg::preg_t [`IS_NUM-1:0]       rd_addr2_i,
  output regread_pkg::data_t [`IS_NUM-1:0]            rd_data1_o,
  output regread_pkg::data_t [`IS_NUM-1:0]            rd_data2_o
);

  // storage
  regread_pkg::data_t regs [`PHY_REG_NUM];

  // hit[s][w]: slot s source matches an enabled write port w
  logic [`IS_NUM-1:0][`CDB_NUM-1:0] hit1;
  logic [`IS_NUM-1:0][`CDB_NUM-1:0] hit2;

  // ------------------------------------------------------------------------
  // read select for one source
  // ------------------------------------------------------------------------
  // zero reg first, then forwarded data, then the stored word
  // scanning w upward lets the higher port override, same as the write

  function automatic regread_pkg::data_t sel_rd(
    input regread_pkg::preg_t                  addr,
    input logic [`CDB_NUM-1:0]                 hit,
    input regread_pkg::data_t                  stored,
    input regread_pkg::data_t [`CDB_NUM-1:0]   fwd
  );
    regread_pkg::data_t res;
    res = stored;
    for (int w = 0; w < `CDB_NUM; w++) begin
      if (hit[w]) res = fwd[w];   // internal forwarding
    end
    if (addr == regread_pkg::preg_t'(`ZERO_REG)) begin
      res = '0;                   // hard zero wins over everything
    end
    return res;
  endfunction

  // ------------------------------------------------------------------------
  // hit detection
  // ------------------------------------------------------------------------
  // each write port qualified by its own enable

  always_comb begin
    hit1 = '0;
    hit2 = '0;
    for (int s = 0; s < `IS_NUM; s++) begin
      for (int w = 0; w < `CDB_NUM; w++) begin
        hit1[s][w] = wr_en_i[w] && (wr_addr_i[w] == rd_addr1_i[s]);
        hit2[s][w] = wr_en_i[w] && (wr_addr_i[w] == rd_addr2_i[s]);
      end
    end
  end

  // ------------------------------------------------------------------------
  // read ports
  // ------------------------------------------------------------------------

  always_comb begin
    for (int s = 0; s < `IS_NUM; s++) begin
      rd_data1_o[s] = sel_rd(rd_addr1_i[s], hit1[s], regs[rd_addr1_i[s]], wr_data_i);
      rd_data2_o[s] = sel_rd(rd_addr2_i[s], hit2[s], regs[rd_addr2_i[s]], wr_data_i);
    end
  end

  // ------------------------------------------------------------------------
  // write ports
  // ------------------------------------------------------------------------
  // visible through the array from the next cycle on

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `PHY_REG_NUM; r++) begin
        regs[r] <= '0;            // whole file starts at zero
      end
    end else begin
      for (int w = 0; w < `CDB_NUM; w++) begin
        if (wr_en_i[w]) begin
          regs[wr_addr_i[w]] <= wr_data_i[w];   // last port wins
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- regread_consts.svh
// widths and counts for the register-read slice
// IS_NUM, CDB_NUM and FU_NUM may change, but the tests assume 2, 2 and 4
// PREG_W must cover PHY_REG_NUM
`ifndef REGREAD_CONSTS_SVH
`define REGREAD_CONSTS_SVH

// ------------------------------------------------------------------------
// datapath
// ------------------------------------------------------------------------
`define XLEN         32   // register value width
`define PHY_REG_NUM  64   // physical registers
`define PREG_W       6    // log2 of PHY_REG_NUM
`define TAG_W        5    // rob tag width

// ------------------------------------------------------------------------
// port counts
// ------------------------------------------------------------------------
`define IS_NUM       2    // issue slots, two reads each
`define CDB_NUM      2    // cdb write ports
`define FU_NUM       4    // completion requesters
`define ZERO_REG     0    // hard zero physical index

`endif

//--- regread_pkg.sv
// shared scalar types for the register-read slice
// widths come from the consts header, so keep PREG_W in step with PHY_REG_NUM
`default_nettype none

`include "regread_consts.svh"

package regread_pkg;

  // ------------------------------------------------------------------------
  // payload
  // ------------------------------------------------------------------------

  // one architectural word as held in the prf
  typedef logic [`XLEN-1:0] data_t;

  // ------------------------------------------------------------------------
  // identifiers
  // ------------------------------------------------------------------------

  // physical register index, 0 is the hard zero
  typedef logic [`PREG_W-1:0] preg_t;

  // rob tag, travels with an issued instruction
  // only carried through here, never decoded
  typedef logic [`TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

//--- regread_sva.sv
// bound checks on cdb grants and on the hard zero register
// sampled on the rising edge, off while reset is high
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module regread_sva (
  input wire logic                                 clk_i,
  input wire logic                                 rst_i,
  input wire logic [`FU_NUM-1:0]                   fu_req_i,
  input wire logic [`FU_NUM-1:0]                   fu_gnt_o,
  input wire logic [`IS_NUM-1:0]                   is_valid_i,
  input wire regread_pkg::preg_t [`IS_NUM-1:0]     is_src1_i,
  input wire regread_pkg::preg_t [`IS_NUM-1:0]     is_src2_i,
  input wire regread_pkg::data_t [`IS_NUM-1:0]     op_data1_o,
  input wire regread_pkg::data_t [`IS_NUM-1:0]     op_data2_o
);

  // never more winners than cdb ports
  gnt_count_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $countones(fu_gnt_o) <= `CDB_NUM)
    else $error("more grants than cdb ports");

  // a grant only goes to a requester
  gnt_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (fu_gnt_o & ~fu_req_i) == '0)
    else $error("grant without a request");

  // ------------------------------------------------------------------------
  // hard zero, one cycle after issue
  // ------------------------------------------------------------------------
  for (genvar s = 0; s < `IS_NUM; s++) begin : g_zero
    zero_src1_a: assert property (@(posedge clk_i) disable iff (rst_i)
      is_valid_i[s] && is_src1_i[s] == regread_pkg::preg_t'(`ZERO_REG)
      |=> op_data1_o[s] == '0)
      else $error("src1 of register 0 read nonzero");
    zero_src2_a: assert property (@(posedge clk_i) disable iff (rst_i)
      is_valid_i[s] && is_src2_i[s] == regread_pkg::preg_t'(`ZERO_REG)
      |=> op_data2_o[s] == '0)
      else $error("src2 of register 0 read nonzero");
  end

endmodule

`default_nettype wire

//--- regread_tb.sv
// file-driven testbench for regread_top, one data line of regread_tests.txt per cycle
// inputs change on the falling edge, grants and cdb are checked 1 ns later
// operands are checked at the next falling edge, one cycle after issue
// table layout assumes IS_NUM 2, CDB_NUM 2, FU_NUM 4
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module regread_tb;

  localparam int MAX_T      = 64;   // table depth
  localparam int RST_CYCLES = 10;

  typedef logic [8*16-1:0] name_t;  // up to 16 chars

  // ------------------------------------------------------------------------
  // dut signals
  // ------------------------------------------------------------------------
  logic                              clk_i;
  logic                              rst_i;
  logic [`FU_NUM-1:0]                fu_req_i;
  regread_pkg::preg_t [`FU_NUM-1:0]  fu_addr_i;
  regread_pkg::data_t [`FU_NUM-1:0]  fu_data_i;
  logic [`FU_NUM-1:0]                fu_gnt_o;
  logic [`CDB_NUM-1:0]               cdb_valid_o;
  regread_pkg::preg_t [`CDB_NUM-1:0] cdb_addr_o;
  regread_pkg::data_t [`CDB_NUM-1:0] cdb_data_o;
  logic [`IS_NUM-1:0]                is_valid_i;
  regread_pkg::tag_t [`IS_NUM-1:0]   is_tag_i;
  regread_pkg::preg_t [`IS_NUM-1:0]  is_src1_i;
  regread_pkg::preg_t [`IS_NUM-1:0]  is_src2_i;
  logic [`IS_NUM-1:0]                op_valid_o;
  regread_pkg::tag_t [`IS_NUM-1:0]   op_tag_o;
  regread_pkg::data_t [`IS_NUM-1:0]  op_data1_o;
  regread_pkg::data_t [`IS_NUM-1:0]  op_data2_o;

  // test table, one entry per data line
  name_t                             t_name  [MAX_T];
  logic [`FU_NUM-1:0]                t_req   [MAX_T];
  regread_pkg::preg_t [`FU_NUM-1:0]  t_addr  [MAX_T];
  regread_pkg::data_t [`FU_NUM-1:0]  t_data  [MAX_T];
  logic [`IS_NUM-1:0]                t_valid [MAX_T];
  regread_pkg::tag_t [`IS_NUM-1:0]   t_tag   [MAX_T];
  regread_pkg::preg_t [`IS_NUM-1:0]  t_src1  [MAX_T];
  regread_pkg::preg_t [`IS_NUM-1:0]  t_src2  [MAX_T];
  regread_pkg::data_t [`IS_NUM-1:0]  t_exp1  [MAX_T];
  regread_pkg::data_t [`IS_NUM-1:0]  t_exp2  [MAX_T];

  int n_tests;
  int cycle_cnt;
  int cycle_limit;   // 0 until the table is in

  regread_top regread_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fu_req_i    (fu_req_i),
    .fu_addr_i   (fu_addr_i),
    .fu_data_i   (fu_data_i),
    .fu_gnt_o    (fu_gnt_o),
    .cdb_valid_o (cdb_valid_o),
    .cdb_addr_o  (cdb_addr_o),
    .cdb_data_o  (cdb_data_o),
    .is_valid_i  (is_valid_i),
    .is_tag_i    (is_tag_i),
    .is_src1_i   (is_src1_i),
    .is_src2_i   (is_src2_i),
    .op_valid_o  (op_valid_o),
    .op_tag_o    (op_tag_o),
    .op_data1_o  (op_data1_o),
    .op_data2_o  (op_data2_o)
  );

  bind regread_top regread_sva regread_sva_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fu_req_i   (fu_req_i),
    .fu_gnt_o   (fu_gnt_o),
    .is_valid_i (is_valid_i),
    .is_src1_i  (is_src1_i),
    .is_src2_i  (is_src2_i),
    .op_data1_o (op_data1_o),
    .op_data2_o (op_data2_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;   // 4 ns period

  // ------------------------------------------------------------------------
  // timeout and error exit
  // ------------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic load_tests();
    int fd;
    int code;
    string line;
    name_t nm;
    logic [`FU_NUM-1:0] req;
    regread_pkg::preg_t a0, a1, a2, a3, x0, y0, x1, y1;
    regread_pkg::data_t d0, d1, d2, d3, e0, f0, e1, f1;
    regread_pkg::tag_t g0, g1;
    logic v0, v1;
    n_tests = 0;
    fd = $fopen("regread_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open regread_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin   // skip blanks, comments
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       nm, req, a0, d0, a1, d1, a2, d2, a3, d3,
                       v0, g0, x0, y0, v1, g1, x1, y1, e0, f0, e1, f1);
        if (code != 22 || n_tests >= MAX_T) begin
          $display("bad or surplus line in regread_tests.txt: %s", line);
          abort_run();
        end
        t_name[n_tests]  = nm;
        t_req[n_tests]   = req;
        t_addr[n_tests]  = {a3, a2, a1, a0};
        t_data[n_tests]  = {d3, d2, d1, d0};
        t_valid[n_tests] = {v1, v0};
        t_tag[n_tests]   = {g1, g0};
        t_src1[n_tests]  = {x1, x0};
        t_src2[n_tests]  = {y1, y0};
        t_exp1[n_tests]  = {e1, e0};
        t_exp2[n_tests]  = {f1, f0};
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_gnt(input name_t name, input logic [`FU_NUM-1:0] exp,
                           input logic [`FU_NUM-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0s: fu_gnt_o expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cdb(input name_t name, input int port,
                           input logic ev, input regread_pkg::preg_t ea,
                           input regread_pkg::data_t ed, input logic av,
                           input regread_pkg::preg_t aa, input regread_pkg::data_t ad);
    if (av !== ev || aa !== ea || ad !== ed) begin
      $display("[FAIL] %0s: cdb port %0d expected v=%b addr=%h data=%h actual v=%b addr=%h data=%h",
               name, port, ev, ea, ed, av, aa, ad);
      abort_run();
    end
  endtask

  task automatic check_valid(input name_t name, input logic [`IS_NUM-1:0] exp,
                             input logic [`IS_NUM-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0s: op_valid_o expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_tag(input name_t name, input int slot,
                           input regread_pkg::tag_t exp, input regread_pkg::tag_t act);
    if (act !== exp) begin
      $display("[FAIL] %0s: op_tag_o[%0d] expected %h actual %h", name, slot, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input name_t name, input string which, input int slot,
                            input regread_pkg::data_t exp, input regread_pkg::data_t act);
    if (act !== exp) begin
      $display("[FAIL] %0s: %0s[%0d] expected %h actual %h", name, which, slot, exp, act);
      abort_run();
    end
  endtask

  // lowest requesters win, at most one per cdb port
  function automatic logic [`FU_NUM-1:0] expect_gnt(input logic [`FU_NUM-1:0] req);
    logic [`FU_NUM-1:0] g;
    int taken;
    g = '0;
    taken = 0;
    for (int i = 0; i < `FU_NUM; i++) begin
      if (req[i] && taken < `CDB_NUM) begin
        g[i] = 1'b1;
        taken++;
      end
    end
    return g;
  endfunction

  // ------------------------------------------------------------------------
  // drive and check one line
  // ------------------------------------------------------------------------
  task automatic drive_idle();
    fu_req_i   = '0;
    fu_addr_i  = '0;
    fu_data_i  = '0;
    is_valid_i = '0;
    is_tag_i   = '0;
    is_src1_i  = '0;
    is_src2_i  = '0;
  endtask

  task automatic drive_line(input int k);
    fu_req_i   = t_req[k];
    fu_addr_i  = t_addr[k];
    fu_data_i  = t_data[k];
    is_valid_i = t_valid[k];
    is_tag_i   = t_tag[k];
    is_src1_i  = t_src1[k];
    is_src2_i  = t_src2[k];
  endtask

  task automatic check_bus(input int k);
    logic [`FU_NUM-1:0] g;
    int p;
    g = expect_gnt(t_req[k]);
    check_gnt(t_name[k], g, fu_gnt_o);
    p = 0;
    for (int i = 0; i < `FU_NUM; i++) begin
      if (g[i]) begin   // next winner takes the next port
        check_cdb(t_name[k], p, 1'b1, t_addr[k][i], t_data[k][i],
                  cdb_valid_o[p], cdb_addr_o[p], cdb_data_o[p]);
        p++;
      end
    end
    for (int q = p; q < `CDB_NUM; q++) begin
      check_cdb(t_name[k], q, 1'b0, '0, '0, cdb_valid_o[q], cdb_addr_o[q], cdb_data_o[q]);
    end
  endtask

  task automatic check_ops(input int k);
    check_valid(t_name[k], t_valid[k], op_valid_o);
    for (int s = 0; s < `IS_NUM; s++) begin
      if (t_valid[k][s]) begin   // idle slot payload is don't care
        check_tag(t_name[k], s, t_tag[k][s], op_tag_o[s]);
        check_data(t_name[k], "op_data1_o", s, t_exp1[k][s], op_data1_o[s]);
        check_data(t_name[k], "op_data2_o", s, t_exp2[k][s], op_data2_o[s]);
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    cycle_cnt   = 0;
    cycle_limit = 0;
    rst_i       = 1'b1;
    drive_idle();
    load_tests();
    cycle_limit = n_tests + 20;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_valid("reset", '0, op_valid_o);   // nothing issued yet
    check_gnt("reset", '0, fu_gnt_o);
    for (int k = 0; k < n_tests; k++) begin
      drive_line(k);   // on the falling edge
      #1;
      check_bus(k);
      @(negedge clk_i);
      check_ops(k);   // issue of line k, after one rising edge
    end
    drive_idle();
    @(negedge clk_i);
    check_valid("drain", '0, op_valid_o);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- regread_tests.txt
# name req fu0..fu3 as addr data | slot0 v tag src1 src2 | slot1 v tag src1 src2 | exp d1_0 d2_0 d1_1 d2_1
# all hex, one line per cycle, expected operands are seen one cycle after their line
rst_rd0 0 00 00000000 00 00000000 00 00000000 00 00000000 1 01 01 02 1 02 03 04 00000000 00000000 00000000 00000000
rst_rd1 0 00 00000000 00 00000000 00 00000000 00 00000000 1 03 05 06 1 04 07 08 00000000 00000000 00000000 00000000
rst_rd2 0 00 00000000 00 00000000 00 00000000 00 00000000 1 05 10 11 1 06 20 21 00000000 00000000 00000000 00000000
rst_rd3 0 00 00000000 00 00000000 00 00000000 00 00000000 1 07 30 31 1 08 3e 3f 00000000 00000000 00000000 00000000
wr_a    1 05 11110005 00 00000000 00 00000000 00 00000000 0 00 00 00 0 00 00 00 00000000 00000000 00000000 00000000
wr_b    0 00 00000000 00 00000000 00 00000000 00 00000000 1 09 05 00 0 00 00 00 11110005 00000000 00000000 00000000
wr_c    0 00 00000000 00 00000000 00 00000000 00 00000000 0 00 00 00 1 0a 05 06 00000000 00000000 11110005 00000000
fwd_a   2 00 00000000 07 22220007 00 00000000 00 00000000 1 0b 07 07 1 0c 07 05 22220007 22220007 22220007 11110005
fwd_b   0 00 00000000 00 00000000 00 00000000 00 00000000 1 0d 07 00 0 00 00 00 22220007 00000000 00000000 00000000
fwd_c   3 08 33330008 09 44440009 00 00000000 00 00000000 1 0e 08 09 1 0f 09 08 33330008 44440009 44440009 33330008
arb4_a  f 0a aaaa000a 0b bbbb000b 0c cccc000c 0d dddd000d 1 10 0c 0d 0 00 00 00 00000000 00000000 00000000 00000000
arb4_b  c 0a aaaa000a 0b bbbb000b 0c cccc000c 0d dddd000d 1 11 0a 0b 1 12 0c 0d aaaa000a bbbb000b cccc000c dddd000d
arb4_c  0 00 00000000 00 00000000 00 00000000 00 00000000 1 13 0c 0d 0 00 00 00 cccc000c dddd000d 00000000 00000000
arb3_a  d 0e eeee000e 00 00000000 0f ffff000f 10 10100010 0 00 00 00 0 00 00 00 00000000 00000000 00000000 00000000
arb3_b  9 11 abcd0011 00 00000000 0f ffff000f 10 10100010 1 14 10 11 1 15 0e 0f 10100010 abcd0011 eeee000e ffff000f
arb3_c  0 00 00000000 00 00000000 00 00000000 00 00000000 0 00 00 00 1 16 10 11 00000000 00000000 10100010 abcd0011
zero_a  1 00 deadbeef 00 00000000 00 00000000 00 00000000 1 17 00 00 1 18 00 05 00000000 00000000 00000000 11110005
zero_b  0 00 00000000 00 00000000 00 00000000 00 00000000 1 19 00 00 0 00 00 00 00000000 00000000 00000000 00000000
zero_c  3 12 12120012 00 cafef00d 00 00000000 00 00000000 1 1a 00 12 0 00 00 00 00000000 12120012 00000000 00000000
dual_a  0 00 00000000 00 00000000 00 00000000 00 00000000 1 1e 08 09 1 0f 0a 0b 33330008 44440009 aaaa000a bbbb000b
dual_b  0 00 00000000 00 00000000 00 00000000 00 00000000 0 00 00 00 1 15 12 0e 00000000 00000000 12120012 eeee000e
dual_c  0 00 00000000 00 00000000 00 00000000 00 00000000 0 00 00 00 0 00 00 00 00000000 00000000 00000000 00000000

//--- regread_top.sv
// register-read slice top, arbiter -> prf -> operand register
// completions broadcast on the cdb, issue reads see same-cycle cdb data
// operands leave one cycle after issue
`timescale 1ns/1ps
`default_nettype none

`include "regread_consts.svh"

module regread_top (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_i,
  // completion side
  input  wire logic [`FU_NUM-1:0]                     fu_req_i,
  input  wire regread_pkg::preg_t [`FU_NUM-1:0]       fu_addr_i,
  input  wire regread_pkg::data_t [`FU_NUM-1:0]       fu_data_i,
  output logic [`FU_NUM-1:0]                          fu_gnt_o,
  // cdb, visible outside too
  output logic [`CDB_NUM-1:0]                         cdb_valid_o,
  output regread_pkg::preg_t [`CDB_NUM-1:0]           cdb_addr_o,
  output regread_pkg::data_t [`CDB_NUM-1:0]           cdb_data_o,
  // issue side
  input  wire logic [`IS_NUM-1:0]                     is_valid_i,
  input  wire regread_pkg::tag_t [`IS_NUM-1:0]        is_tag_i,
  input  wire regread_pkg::preg_t [`IS_NUM-1:0]       is_src1_i,
  input  wire regread_pkg::preg_t [`IS_NUM-1:0]       is_src2_i,
  // to execute
  output logic [`IS_NUM-1:0]                          op_valid_o,
  output regread_pkg::tag_t [`IS_NUM-1:0]             op_tag_o,
  output regread_pkg::data_t [`IS_NUM-1:0]            op_data1_o,
  output regread_pkg::data_t [`IS_NUM-1:0]            op_data2_o
);

  // ------------------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------------------
  logic [`CDB_NUM-1:0]                cdb_valid;
  regread_pkg::preg_t [`CDB_NUM-1:0]  cdb_addr;
  regread_pkg::data_t [`CDB_NUM-1:0]  cdb_data;
  regread_pkg::data_t [`IS_NUM-1:0]   src1_data;   // prf read, pre register
  regread_pkg::data_t [`IS_NUM-1:0]   src2_data;

  assign cdb_valid_o = cdb_valid;
  assign cdb_addr_o  = cdb_addr;
  assign cdb_data_o  = cdb_data;

  cdb_arbiter cdb_arbiter_i (
    .fu_req_i    (fu_req_i),
    .fu_addr_i   (fu_addr_i),
    .fu_data_i   (fu_data_i),
    .fu_gnt_o    (fu_gnt_o),
    .cdb_valid_o (cdb_valid),
    .cdb_addr_o  (cdb_addr),
    .cdb_data_o  (cdb_data)
  );

  phys_regfile phys_regfile_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_en_i    (cdb_valid),    // cdb port p is prf write port p
    .wr_addr_i  (cdb_addr),
    .wr_data_i  (cdb_data),
    .rd_addr1_i (is_src1_i),
    .rd_addr2_i (is_src2_i),
    .rd_data1_o (src1_data),
    .rd_data2_o (src2_data)
  );

  operand_read operand_read_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .is_valid_i  (is_valid_i),
    .is_tag_i    (is_tag_i),
    .src1_data_i (src1_data),
    .src2_data_i (src2_data),
    .op_valid_o  (op_valid_o),
    .op_tag_o    (op_tag_o),
    .op_data1_o  (op_data1_o),
    .op_data2_o  (op_data2_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the register-read testbench with verilator and runs it
# exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f sim.f --top-module regread_tb -o regread_sim \
  && ./obj_dir/regread_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+.
regread_pkg.sv
cdb_arbiter.sv
phys_regfile.sv
operand_read.sv
regread_top.sv
regread_sva.sv
regread_tb.sv
